// ==== verilog/sb_pkg.sv ====
package sb_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [2:0]  fu_id_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  fu_op_t;

    localparam int num_fu = 4;

    localparam fu_id_t fu_none = 3'd0;
    localparam fu_id_t fu_alu  = 3'd1;
    localparam fu_id_t fu_mem  = 3'd2;
    localparam fu_id_t fu_mul  = 3'd3;
    localparam fu_id_t fu_div  = 3'd4;

    // alu ops, bit 4 marks the immediate form
    localparam fu_op_t alu_add   = 5'h01;
    localparam fu_op_t alu_sub   = 5'h02;
    localparam fu_op_t alu_and   = 5'h03;
    localparam fu_op_t alu_or    = 5'h04;
    localparam fu_op_t alu_xor   = 5'h05;
    localparam fu_op_t alu_sll   = 5'h06;
    localparam fu_op_t alu_srl   = 5'h07;
    localparam fu_op_t alu_slt   = 5'h08;
    localparam fu_op_t alu_sltu  = 5'h09;
    localparam fu_op_t alu_sra   = 5'h0a;
    localparam fu_op_t alu_imm   = 5'h10;
    localparam fu_op_t alu_lui   = 5'h1b;
    localparam fu_op_t alu_auipc = 5'h1c;

    // mem ops are {1'b0, size, we}
    localparam fu_op_t mem_lb  = 5'b0_000_0;
    localparam fu_op_t mem_lh  = 5'b0_001_0;
    localparam fu_op_t mem_lw  = 5'b0_010_0;
    localparam fu_op_t mem_lbu = 5'b0_100_0;
    localparam fu_op_t mem_lhu = 5'b0_101_0;
    localparam fu_op_t mem_sb  = 5'b0_000_1;
    localparam fu_op_t mem_sh  = 5'b0_001_1;
    localparam fu_op_t mem_sw  = 5'b0_010_1;

    localparam fu_op_t mul_mul    = 5'd0;
    localparam fu_op_t mul_mulh   = 5'd1;
    localparam fu_op_t mul_mulhsu = 5'd2;
    localparam fu_op_t mul_mulhu  = 5'd3;
    localparam fu_op_t div_div    = 5'd0;
    localparam fu_op_t div_divu   = 5'd1;
    localparam fu_op_t div_rem    = 5'd2;
    localparam fu_op_t div_remu   = 5'd3;

    localparam logic [6:0] opc_r     = 7'b0110011;
    localparam logic [6:0] opc_i     = 7'b0010011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;

    localparam logic [6:0] f7_base   = 7'h00;
    localparam logic [6:0] f7_muldiv = 7'h01;
    localparam logic [6:0] f7_alt    = 7'h20;

    // one status entry per unit
    typedef struct packed {
        logic     busy;
        fu_op_t   op;
        reg_idx_t dst;
        reg_idx_t src1;
        reg_idx_t src2;
        fu_id_t   fu1;   // producer of src1, none when settled
        fu_id_t   fu2;
        logic     rdy1;  // set until operands are read
        logic     rdy2;
        logic     done;
    } fu_entry_t;

endpackage

// ==== verilog/inst_decode.sv ====
module inst_decode (
    input  sb_pkg::inst_t    inst,
    output logic             dec_valid,
    output sb_pkg::fu_id_t   dec_fu,
    output sb_pkg::fu_op_t   dec_op,
    output sb_pkg::reg_idx_t dec_dst,
    output sb_pkg::reg_idx_t dec_src1,
    output sb_pkg::reg_idx_t dec_src2
);
    import sb_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       has_dst;
    logic       has_src1;
    logic       has_src2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign alt    = (funct7 == f7_alt);

    // shared by the register and immediate alu forms
    function automatic fu_op_t alu_op(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'h0:    return sel_alt ? alu_sub : alu_add;
            3'h1:    return alu_sll;
            3'h2:    return alu_slt;
            3'h3:    return alu_sltu;
            3'h4:    return alu_xor;
            3'h5:    return sel_alt ? alu_sra : alu_srl;
            3'h6:    return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        dec_valid = 1'b0;
        dec_fu    = fu_none;
        dec_op    = '0;
        has_dst   = 1'b1;
        has_src1  = 1'b1;
        has_src2  = 1'b0;
        case (opcode)
            opc_r: begin
                has_src2 = 1'b1;
                if (funct7 == f7_muldiv) begin
                    dec_valid = 1'b1;
                    dec_fu    = funct3[2] ? fu_div : fu_mul;
                    case (funct3)
                        3'h0:    dec_op = mul_mul;
                        3'h1:    dec_op = mul_mulh;
                        3'h2:    dec_op = mul_mulhsu;
                        3'h3:    dec_op = mul_mulhu;
                        3'h4:    dec_op = div_div;
                        3'h5:    dec_op = div_divu;
                        3'h6:    dec_op = div_rem;
                        default: dec_op = div_remu;
                    endcase
                end else begin
                    // sub and sra are the only alt encodings
                    dec_valid = (funct7 == f7_base) || (alt && (funct3 == 3'h0 || funct3 == 3'h5));
                    dec_fu    = fu_alu;
                    dec_op    = alu_op(funct3, alt);
                end
            end
            opc_i: begin
                dec_fu = fu_alu;
                dec_op = alu_op(funct3, alt && funct3 == 3'h5) | alu_imm;
                case (funct3)
                    3'h1:    dec_valid = (funct7 == f7_base);
                    3'h5:    dec_valid = (funct7 == f7_base) || alt;
                    default: dec_valid = 1'b1;
                endcase
            end
            opc_load: begin
                dec_fu    = fu_mem;
                dec_valid = 1'b1;
                case (funct3)
                    3'h0:    dec_op = mem_lb;
                    3'h1:    dec_op = mem_lh;
                    3'h2:    dec_op = mem_lw;
                    3'h4:    dec_op = mem_lbu;
                    3'h5:    dec_op = mem_lhu;
                    default: dec_valid = 1'b0;
                endcase
            end
            opc_store: begin
                dec_fu    = fu_mem;
                dec_valid = 1'b1;
                has_dst   = 1'b0;   // rd field holds imm bits
                has_src2  = 1'b1;
                case (funct3)
                    3'h0:    dec_op = mem_sb;
                    3'h1:    dec_op = mem_sh;
                    3'h2:    dec_op = mem_sw;
                    default: dec_valid = 1'b0;
                endcase
            end
            opc_lui, opc_auipc: begin
                dec_valid = 1'b1;
                dec_fu    = fu_alu;
                dec_op    = (opcode == opc_lui) ? alu_lui : alu_auipc;
                has_src1  = 1'b0;
            end
            default: dec_valid = 1'b0;
        endcase
        if (!dec_valid) begin
            dec_fu = fu_none;   // dropped instruction touches no table
        end
    end

    assign dec_dst  = (dec_valid && has_dst)  ? inst[11:7]  : '0;
    assign dec_src1 = (dec_valid && has_src1) ? inst[19:15] : '0;
    assign dec_src2 = (dec_valid && has_src2) ? inst[24:20] : '0;

endmodule

// ==== verilog/reg_result_status.sv ====
module reg_result_status (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_en,
    input  sb_pkg::reg_idx_t dec_dst,
    input  sb_pkg::reg_idx_t dec_src1,
    input  sb_pkg::reg_idx_t dec_src2,
    input  sb_pkg::fu_id_t   dec_fu,
    input  sb_pkg::fu_id_t   wb_fu,
    input  sb_pkg::reg_idx_t wb_dst,
    output sb_pkg::fu_id_t   src1_fu,
    output sb_pkg::fu_id_t   src2_fu
);
    import sb_pkg::*;

    fu_id_t rrs [32];   // pending writer per register

    assign src1_fu = rrs[dec_src1];
    assign src2_fu = rrs[dec_src2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                rrs[r] <= fu_none;
            end
        end else begin
            if (wb_fu != fu_none) begin
                rrs[wb_dst] <= fu_none;
            end
            // waw stall keeps this off the register being cleared
            if (issue_en && dec_fu != fu_none && dec_dst != '0) begin
                rrs[dec_dst] <= dec_fu;
            end
        end
    end

    // x0 must never look pending to a consumer
    a_x0_free: assert property (@(posedge clk) disable iff (rst) rrs[0] == fu_none)
        else $error("register 0 recorded a pending unit");

endmodule

// ==== verilog/fu_status_table.sv ====
module fu_status_table (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue_en,
    input  sb_pkg::fu_id_t              dec_fu,
    input  sb_pkg::fu_op_t              dec_op,
    input  sb_pkg::reg_idx_t            dec_dst,
    input  sb_pkg::reg_idx_t            dec_src1,
    input  sb_pkg::reg_idx_t            dec_src2,
    input  sb_pkg::fu_id_t              src1_fu,
    input  sb_pkg::fu_id_t              src2_fu,
    input  sb_pkg::fu_id_t              ro_sel,
    input  sb_pkg::fu_id_t              wb_sel,
    input  logic [sb_pkg::num_fu-1:0]   fu_done,
    output sb_pkg::fu_entry_t           entries [1:sb_pkg::num_fu]
);
    import sb_pkg::*;

    fu_entry_t         nxt [1:num_fu];
    fu_id_t            s1_fu;
    fu_id_t            s2_fu;
    logic [num_fu-1:0] busy_vec;

    // a producer retiring on this edge no longer blocks the new entry
    assign s1_fu = (src1_fu == wb_sel) ? fu_none : src1_fu;
    assign s2_fu = (src2_fu == wb_sel) ? fu_none : src2_fu;

    always_comb begin
        for (int u = 1; u <= num_fu; u++) begin
            nxt[u]        = entries[u];
            busy_vec[u-1] = entries[u].busy;

            if (entries[u].busy && fu_done[u-1]) begin
                nxt[u].done = 1'b1;
            end

            // operands read, drop both flags
            if (ro_sel == fu_id_t'(u)) begin
                nxt[u].rdy1 = 1'b0;
                nxt[u].rdy2 = 1'b0;
            end

            // raw wake-up, producer name cleared so it fires only once
            if (wb_sel != fu_none) begin
                if (entries[u].fu1 == wb_sel) begin
                    nxt[u].fu1  = fu_none;
                    nxt[u].rdy1 = 1'b1;
                end
                if (entries[u].fu2 == wb_sel) begin
                    nxt[u].fu2  = fu_none;
                    nxt[u].rdy2 = 1'b1;
                end
            end

            if (wb_sel == fu_id_t'(u)) begin
                nxt[u] = '0;
            end

            if (issue_en && dec_fu == fu_id_t'(u)) begin
                nxt[u] = '{busy: 1'b1,
                           op:   dec_op,
                           dst:  dec_dst,
                           src1: dec_src1,
                           src2: dec_src2,
                           fu1:  s1_fu,
                           fu2:  s2_fu,
                           rdy1: (s1_fu == fu_none),
                           rdy2: (s2_fu == fu_none),
                           done: 1'b0};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int u = 1; u <= num_fu; u++) begin
                entries[u] <= '0;
            end
        end else begin
            entries <= nxt;
        end
    end

    // a unit only finishes work it was handed
    a_done_busy: assert property (@(posedge clk) disable iff (rst) (fu_done & ~busy_vec) == '0)
        else $error("done pulse from an idle unit: %b", fu_done & ~busy_vec);

endmodule

// ==== verilog/hazard_arbiter.sv ====
module hazard_arbiter (
    input  logic              dec_valid,
    input  sb_pkg::fu_id_t    dec_fu,
    input  sb_pkg::reg_idx_t  dec_dst,
    input  logic              inst_valid,
    input  sb_pkg::fu_entry_t entries [1:sb_pkg::num_fu],
    output logic              issue_en,
    output sb_pkg::fu_id_t    ro_sel,
    output sb_pkg::fu_id_t    wb_sel
);
    import sb_pkg::*;

    logic              struct_stall;
    logic              waw_stall;
    logic [1:num_fu]   war_ok;

    always_comb begin
        struct_stall = 1'b0;
        waw_stall    = 1'b0;
        for (int u = 1; u <= num_fu; u++) begin
            if (dec_fu == fu_id_t'(u) && entries[u].busy) begin
                struct_stall = 1'b1;
            end
            if (entries[u].busy && dec_dst != '0 && entries[u].dst == dec_dst) begin
                waw_stall = 1'b1;
            end
        end
    end

    // undecodable words are taken and dropped
    assign issue_en = inst_valid && (!dec_valid || !(struct_stall || waw_stall));

    // blocked while another unit still holds a ready flag on our dst
    always_comb begin
        for (int u = 1; u <= num_fu; u++) begin
            war_ok[u] = 1'b1;
            for (int v = 1; v <= num_fu; v++) begin
                if (v != u && entries[u].dst != '0 &&
                    ((entries[v].rdy1 && entries[v].src1 == entries[u].dst) ||
                     (entries[v].rdy2 && entries[v].src2 == entries[u].dst))) begin
                    war_ok[u] = 1'b0;
                end
            end
        end
    end

    // walking down lets the lowest id win, so alu has priority
    always_comb begin
        ro_sel = fu_none;
        wb_sel = fu_none;
        for (int u = num_fu; u >= 1; u--) begin
            if (entries[u].busy && entries[u].rdy1 && entries[u].rdy2) begin
                ro_sel = fu_id_t'(u);
            end
            if (entries[u].done && war_ok[u]) begin
                wb_sel = fu_id_t'(u);
            end
        end
        a_wb_busy: assert (wb_sel == fu_none || entries[wb_sel].busy)
            else $error("write-back grant to idle unit %0d", wb_sel);
    end

endmodule

// ==== verilog/scoreboard_ctrl.sv ====
module scoreboard_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  sb_pkg::inst_t             inst,
    input  logic                      inst_valid,
    input  logic [sb_pkg::num_fu-1:0] fu_done,
    output logic                      issue_ack,
    output logic [sb_pkg::num_fu-1:0] ro_en,
    output sb_pkg::fu_op_t            ro_op,
    output sb_pkg::reg_idx_t          rs1_ctrl,
    output sb_pkg::reg_idx_t          rs2_ctrl,
    output logic                      reg_write,
    output sb_pkg::fu_id_t            wb_fu,
    output sb_pkg::reg_idx_t          rd_ctrl
);
    import sb_pkg::*;

    logic      dec_valid;
    fu_id_t    dec_fu;
    fu_op_t    dec_op;
    reg_idx_t  dec_dst;
    reg_idx_t  dec_src1;
    reg_idx_t  dec_src2;
    fu_id_t    src1_fu;
    fu_id_t    src2_fu;
    logic      issue_en;
    fu_id_t    ro_sel;
    fu_id_t    wb_sel;
    fu_entry_t entries [1:num_fu];

    inst_decode u_decode (
        .inst(inst), .dec_valid(dec_valid), .dec_fu(dec_fu), .dec_op(dec_op),
        .dec_dst(dec_dst), .dec_src1(dec_src1), .dec_src2(dec_src2)
    );

    reg_result_status u_rrs (
        .clk(clk), .rst(rst), .issue_en(issue_en),
        .dec_dst(dec_dst), .dec_src1(dec_src1), .dec_src2(dec_src2), .dec_fu(dec_fu),
        .wb_fu(wb_sel), .wb_dst(rd_ctrl), .src1_fu(src1_fu), .src2_fu(src2_fu)
    );

    fu_status_table u_fus (
        .clk(clk), .rst(rst), .issue_en(issue_en), .dec_fu(dec_fu), .dec_op(dec_op),
        .dec_dst(dec_dst), .dec_src1(dec_src1), .dec_src2(dec_src2),
        .src1_fu(src1_fu), .src2_fu(src2_fu), .ro_sel(ro_sel), .wb_sel(wb_sel),
        .fu_done(fu_done), .entries(entries)
    );

    hazard_arbiter u_arb (
        .dec_valid(dec_valid), .dec_fu(dec_fu), .dec_dst(dec_dst),
        .inst_valid(inst_valid), .entries(entries),
        .issue_en(issue_en), .ro_sel(ro_sel), .wb_sel(wb_sel)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_ack <= 1'b0;
        end else begin
            issue_ack <= issue_en;   // one cycle per taken instruction
        end
    end

    // route the granted entries out
    always_comb begin
        ro_en    = '0;
        ro_op    = '0;
        rs1_ctrl = '0;
        rs2_ctrl = '0;
        rd_ctrl  = '0;
        for (int u = 1; u <= num_fu; u++) begin
            if (ro_sel == fu_id_t'(u)) begin
                ro_en[u-1] = 1'b1;
                ro_op      = entries[u].op;
                rs1_ctrl   = entries[u].src1;
                rs2_ctrl   = entries[u].src2;
            end
            if (wb_sel == fu_id_t'(u)) begin
                rd_ctrl = entries[u].dst;
            end
        end
    end

    assign reg_write = (wb_sel != fu_none);
    assign wb_fu     = wb_sel;

endmodule

// ==== dv/tb_scoreboard.sv ====
module tb_scoreboard;
    timeunit 1ns;
    timeprecision 100ps;
    import sb_pkg::*;

    logic              clk;
    logic              rst;
    inst_t             inst;
    logic              inst_valid;
    logic [num_fu-1:0] fu_done;
    logic              issue_ack;
    logic [num_fu-1:0] ro_en;
    fu_op_t            ro_op;
    reg_idx_t          rs1_ctrl;
    reg_idx_t          rs2_ctrl;
    logic              reg_write;
    fu_id_t            wb_fu;
    reg_idx_t          rd_ctrl;

    // reference model of the scoreboard state
    logic     m_busy [1:num_fu];
    logic     m_read [1:num_fu];
    logic     m_done [1:num_fu];
    fu_op_t   m_op   [1:num_fu];
    reg_idx_t m_dst  [1:num_fu];
    reg_idx_t m_src1 [1:num_fu];
    reg_idx_t m_src2 [1:num_fu];
    fu_id_t   m_w1   [1:num_fu];   // producer still owed to src1
    fu_id_t   m_w2   [1:num_fu];
    fu_id_t   pend   [32];
    // model view including the instruction acknowledged this cycle
    logic     e_busy [1:num_fu];
    logic     e_read [1:num_fu];
    fu_op_t   e_op   [1:num_fu];
    reg_idx_t e_dst  [1:num_fu];
    reg_idx_t e_src1 [1:num_fu];
    reg_idx_t e_src2 [1:num_fu];
    fu_id_t   e_w1   [1:num_fu];
    fu_id_t   e_w2   [1:num_fu];
    logic     wb_war_ok;

    fu_id_t   ack_fu;
    fu_op_t   ack_op;
    reg_idx_t ack_rd;
    reg_idx_t ack_rs1;
    reg_idx_t ack_rs2;
    logic     offered_any;

    logic [num_fu-1:0] ro_q;
    logic [num_fu-1:0] hold;
    int                cnt [num_fu];

    scoreboard_ctrl dut (
        .clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .fu_done(fu_done),
        .issue_ack(issue_ack), .ro_en(ro_en), .ro_op(ro_op), .rs1_ctrl(rs1_ctrl),
        .rs2_ctrl(rs2_ctrl), .reg_write(reg_write), .wb_fu(wb_fu), .rd_ctrl(rd_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic fu_id_t ro_unit(input logic [num_fu-1:0] en);
        for (int u = 1; u <= num_fu; u++) begin
            if (en[u-1]) return fu_id_t'(u);
        end
        return fu_none;
    endfunction

    // true when no unit still has to read reg r before it is overwritten by unit w
    function automatic logic war_clear(input fu_id_t w, input reg_idx_t r);
        for (int v = 1; v <= num_fu; v++) begin
            if (v != w && r != '0 && e_busy[v] && !e_read[v] &&
                ((e_src1[v] == r && e_w1[v] == fu_none) ||
                 (e_src2[v] == r && e_w2[v] == fu_none))) return 1'b0;
        end
        return 1'b1;
    endfunction

    always_comb begin
        for (int u = 1; u <= num_fu; u++) begin
            e_busy[u] = m_busy[u];
            e_read[u] = m_read[u];
            e_op[u]   = m_op[u];
            e_dst[u]  = m_dst[u];
            e_src1[u] = m_src1[u];
            e_src2[u] = m_src2[u];
            e_w1[u]   = m_w1[u];
            e_w2[u]   = m_w2[u];
        end
        if (issue_ack && ack_fu != fu_none) begin
            e_busy[ack_fu] = 1'b1;
            e_read[ack_fu] = 1'b0;
            e_op[ack_fu]   = ack_op;
            e_dst[ack_fu]  = ack_rd;
            e_src1[ack_fu] = ack_rs1;
            e_src2[ack_fu] = ack_rs2;
            e_w1[ack_fu]   = pend[ack_rs1];
            e_w2[ack_fu]   = pend[ack_rs2];
        end
    end

    // war clearance of the unit writing back this cycle
    always_comb begin
        wb_war_ok = war_clear(wb_fu, e_dst[wb_fu]);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int u = 1; u <= num_fu; u++) begin
                m_busy[u] <= 1'b0;
                m_read[u] <= 1'b0;
                m_done[u] <= 1'b0;
                m_op[u]   <= '0;
                m_dst[u]  <= '0;
                m_src1[u] <= '0;
                m_src2[u] <= '0;
                m_w1[u]   <= fu_none;
                m_w2[u]   <= fu_none;
            end
            for (int r = 0; r < 32; r++) begin
                pend[r] <= fu_none;
            end
        end else begin
            for (int u = 1; u <= num_fu; u++) begin
                m_busy[u] <= e_busy[u];
                m_read[u] <= e_read[u] | ro_en[u-1];
                m_done[u] <= m_done[u] | fu_done[u-1];
                m_op[u]   <= e_op[u];
                m_dst[u]  <= e_dst[u];
                m_src1[u] <= e_src1[u];
                m_src2[u] <= e_src2[u];
                m_w1[u]   <= (reg_write && e_w1[u] == wb_fu) ? fu_none : e_w1[u];
                m_w2[u]   <= (reg_write && e_w2[u] == wb_fu) ? fu_none : e_w2[u];
                if (reg_write && wb_fu == fu_id_t'(u)) begin
                    m_busy[u] <= 1'b0;
                    m_read[u] <= 1'b0;
                    m_done[u] <= 1'b0;
                end
            end
            if (reg_write) pend[e_dst[wb_fu]] <= fu_none;
            if (issue_ack && ack_rd != '0) pend[ack_rd] <= ack_fu;
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
            !offered_any |-> (!issue_ack && ro_en == '0 && !reg_write))
        else stop_run("activity on the outputs before any instruction was offered");
    a_issue_free: assert property (@(posedge clk) disable iff (rst)
            issue_ack |-> !m_busy[ack_fu])
        else stop_run($sformatf("structural hazard, unit %0d issued while busy", ack_fu));
    a_issue_waw: assert property (@(posedge clk) disable iff (rst)
            issue_ack |-> (ack_rd == '0 || !((m_busy[1] && m_dst[1] == ack_rd) ||
            (m_busy[2] && m_dst[2] == ack_rd) || (m_busy[3] && m_dst[3] == ack_rd) ||
            (m_busy[4] && m_dst[4] == ack_rd))))
        else stop_run($sformatf("waw hazard, x%0d issued while a unit owns it", ack_rd));
    a_ro_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ro_en))
        else stop_run($sformatf("ro_en is not one-hot: %b", ro_en));
    a_ro_once: assert property (@(posedge clk) disable iff (rst)
            ro_en != '0 |-> (e_busy[ro_unit(ro_en)] && !e_read[ro_unit(ro_en)]))
        else stop_run($sformatf("ro_en %b for an idle unit or a second time", ro_en));
    a_ro_raw: assert property (@(posedge clk) disable iff (rst)
            ro_en != '0 |-> (e_w1[ro_unit(ro_en)] == fu_none && e_w2[ro_unit(ro_en)] == fu_none))
        else stop_run("raw hazard, operands read before the producer wrote back");
    a_ro_op: assert property (@(posedge clk) disable iff (rst)
            ro_en != '0 |-> ro_op == e_op[ro_unit(ro_en)])
        else stop_run($sformatf("mismatch at %0t: ro_op got %h expected %h",
            $time, ro_op, e_op[ro_unit(ro_en)]));
    a_ro_rs1: assert property (@(posedge clk) disable iff (rst)
            ro_en != '0 |-> rs1_ctrl == e_src1[ro_unit(ro_en)])
        else stop_run($sformatf("mismatch at %0t: rs1_ctrl got %0d expected %0d",
            $time, rs1_ctrl, e_src1[ro_unit(ro_en)]));
    a_ro_rs2: assert property (@(posedge clk) disable iff (rst)
            ro_en != '0 |-> rs2_ctrl == e_src2[ro_unit(ro_en)])
        else stop_run($sformatf("mismatch at %0t: rs2_ctrl got %0d expected %0d",
            $time, rs2_ctrl, e_src2[ro_unit(ro_en)]));
    a_wb_done: assert property (@(posedge clk) disable iff (rst)
            reg_write |-> (wb_fu >= 1 && wb_fu <= num_fu && m_busy[wb_fu] && m_done[wb_fu]))
        else stop_run($sformatf("write-back of unit %0d before its done pulse", wb_fu));
    a_wb_rd: assert property (@(posedge clk) disable iff (rst)
            reg_write |-> rd_ctrl == e_dst[wb_fu])
        else stop_run($sformatf("mismatch at %0t: rd_ctrl got %0d expected %0d",
            $time, rd_ctrl, e_dst[wb_fu]));
    a_wb_war: assert property (@(posedge clk) disable iff (rst)
            reg_write |-> wb_war_ok)
        else stop_run($sformatf("war hazard, x%0d written before a pending read", rd_ctrl));

    // unit model answers each operand read with a done pulse
    always @(negedge clk) ro_q <= ro_en;

    always @(posedge clk) begin
        #1;
        fu_done = '0;
        for (int u = 0; u < num_fu; u++) begin
            if (rst) begin
                cnt[u] = 0;
            end else begin
                if (cnt[u] > 1 || (cnt[u] == 1 && !hold[u])) begin
                    cnt[u]--;
                    if (cnt[u] == 0) fu_done[u] = 1'b1;
                end
                if (ro_q[u]) cnt[u] = 1 + ($urandom % 6);
            end
        end
    end

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_r};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(input reg_idx_t rs2, input reg_idx_t rs1,
                                    input logic [2:0] f3);
        return {7'd0, rs2, rs1, f3, 5'd0, opc_store};
    endfunction

    // hold the word until it is taken, then record what the model expects
    task automatic offer(input inst_t w, input fu_id_t fu, input fu_op_t op,
                         input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        int n;
        n = 0;
        offered_any = 1'b1;
        inst        = w;
        inst_valid  = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 200) stop_run("timeout waiting for issue_ack");
        end while (!issue_ack);
        inst_valid = 1'b0;
        ack_fu     = fu;
        ack_op     = op;
        ack_rd     = rd;
        ack_rs1    = rs1;
        ack_rs2    = rs2;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (m_busy[1] || m_busy[2] || m_busy[3] || m_busy[4] || issue_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 300) stop_run("timeout waiting for the units to write back");
        end
    endtask

    initial begin
        void'($urandom(32'h425db957));
        rst         = 1'b1;
        inst        = '0;
        inst_valid  = 1'b0;
        fu_done     = '0;
        hold        = '0;
        offered_any = 1'b0;
        ack_fu      = fu_none;
        ack_op      = '0;
        ack_rd      = '0;
        ack_rs1     = '0;
        ack_rs2     = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (8) @(posedge clk);
        #1;

        // independent work on every unit
        offer(enc_r(f7_base, 5'd3, 5'd2, 3'h0, 5'd1), fu_alu, 5'h01, 5'd1, 5'd2, 5'd3);
        offer(enc_i(12'd8, 5'd5, 3'h2, 5'd4, opc_load), fu_mem, 5'h04, 5'd4, 5'd5, 5'd0);
        offer(enc_r(f7_muldiv, 5'd8, 5'd7, 3'h0, 5'd6), fu_mul, 5'h00, 5'd6, 5'd7, 5'd8);
        offer(enc_r(f7_muldiv, 5'd11, 5'd10, 3'h4, 5'd9), fu_div, 5'h00, 5'd9, 5'd10, 5'd11);
        offer(enc_s(5'd12, 5'd13, 3'h2), fu_mem, 5'h05, 5'd0, 5'd13, 5'd12);
        offer(enc_i(12'd5, 5'd15, 3'h0, 5'd14, opc_i), fu_alu, 5'h11, 5'd14, 5'd15, 5'd0);
        drain();

        // structural, then raw, then waw on an idle mem unit
        offer(enc_r(f7_muldiv, 5'd2, 5'd1, 3'h0, 5'd16), fu_mul, 5'h00, 5'd16, 5'd1, 5'd2);
        offer(enc_r(f7_muldiv, 5'd4, 5'd3, 3'h1, 5'd17), fu_mul, 5'h01, 5'd17, 5'd3, 5'd4);
        offer(enc_r(f7_muldiv, 5'd2, 5'd1, 3'h5, 5'd20), fu_div, 5'h01, 5'd20, 5'd1, 5'd2);
        offer(enc_r(f7_alt, 5'd3, 5'd20, 3'h0, 5'd21), fu_alu, 5'h02, 5'd21, 5'd20, 5'd3);
        offer(enc_r(f7_muldiv, 5'd2, 5'd1, 3'h3, 5'd22), fu_mul, 5'h03, 5'd22, 5'd1, 5'd2);
        offer(enc_i(12'd0, 5'd1, 3'h2, 5'd22, opc_load), fu_mem, 5'h04, 5'd22, 5'd1, 5'd0);
        drain();

        // the load to x3 has to wait for the add to read x3
        hold[2] = 1'b1;
        offer(enc_r(f7_muldiv, 5'd2, 5'd1, 3'h0, 5'd6), fu_mul, 5'h00, 5'd6, 5'd1, 5'd2);
        offer(enc_r(f7_base, 5'd6, 5'd3, 3'h0, 5'd5), fu_alu, 5'h01, 5'd5, 5'd3, 5'd6);
        offer(enc_i(12'd0, 5'd7, 3'h2, 5'd3, opc_load), fu_mem, 5'h04, 5'd3, 5'd7, 5'd0);
        repeat (16) @(posedge clk);
        #1;
        hold = '0;
        drain();

        repeat (4) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/sb_pkg.sv
verilog/inst_decode.sv
verilog/reg_result_status.sv
verilog/fu_status_table.sv
verilog/hazard_arbiter.sv
verilog/scoreboard_ctrl.sv
dv/tb_scoreboard.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scoreboard
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= sim.f

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
